//--- pmp_access_ctrl.sv
module pmp_access_ctrl import pmp_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic [PADDR_WIDTH-1:0] paddr,
    input  access_e                acc,
    input  priv_e                  priv,
    input  logic                   hit,
    input  logic                   hit_r,
    input  logic                   hit_w,
    input  logic                   hit_x,
    input  logic                   hit_l,
    input  logic                   uc,
    output logic [WADDR_WIDTH-1:0] waddr,
    output logic                   resp_valid,
    output logic                   resp_fault,
    output logic                   resp_uc
);

    logic                   req_q;
    logic [PADDR_WIDTH-1:0] paddr_q;
    access_e                acc_q;
    priv_e                  priv_q;
    logic                   perm;
    logic                   allow;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            paddr_q <= paddr;
            acc_q   <= acc;
            priv_q  <= priv;
        end
    end

    assign waddr = paddr_q[PADDR_WIDTH-1:2];

    always_comb begin
        case (acc_q)
            ACC_READ:  perm = hit_r;
            ACC_WRITE: perm = hit_w;
            ACC_EXEC:  perm = hit_x;
            default:   perm = 1'b0;
        endcase
    end

    // machine mode is only held back by locked entries.
    assign allow = (priv_q == PRIV_M) ? !(hit && hit_l && !perm) : (hit && perm);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            resp_fault <= 1'b0;
            resp_uc    <= 1'b0;
        end else begin
            resp_valid <= req_q;
            resp_fault <= req_q & ~allow;
            resp_uc    <= req_q & uc;
        end
    end

endmodule

//--- pmp_cfg_if.sv
interface pmp_cfg_if import pmp_pkg::*; #(
    parameter int PMP_ENTRIES = pmp_pkg::PMP_ENTRIES,
    parameter int PMA_ENTRIES = pmp_pkg::PMA_ENTRIES
) ();

    pmp_cfg_t [PMP_ENTRIES-1:0]                  pmpcfg;
    logic     [PMP_ENTRIES-1:0][WADDR_WIDTH-1:0] pmpaddr;
    pma_cfg_t [PMA_ENTRIES-1:0]                  pmacfg;
    logic     [PMA_ENTRIES-1:0][WADDR_WIDTH-1:0] pmaaddr;

    modport bank (
        output pmpcfg,
        output pmpaddr,
        output pmacfg,
        output pmaaddr
    );

    modport check (
        input pmpcfg,
        input pmpaddr,
        input pmacfg,
        input pmaaddr
    );

endinterface

//--- pmp_check.sv
module pmp_check import pmp_pkg::*; #(
    parameter int PMP_ENTRIES = pmp_pkg::PMP_ENTRIES,
    parameter int PMA_ENTRIES = pmp_pkg::PMA_ENTRIES
) (
    input  logic [WADDR_WIDTH-1:0] waddr,
    pmp_cfg_if.check               cfg,
    output logic                   hit,
    output logic                   hit_r,
    output logic                   hit_w,
    output logic                   hit_x,
    output logic                   hit_l,
    output logic                   uc
);

    logic [PMP_ENTRIES-1:0] pmp_tor;
    logic [PMP_ENTRIES-1:0] pmp_match;
    logic [PMA_ENTRIES-1:0] pma_tor;
    logic [PMA_ENTRIES-1:0] pma_uc;

    // marks bits [t:0], where t is the number of trailing ones of the address.
    function automatic logic [WADDR_WIDTH-1:0] napot_mask(input logic [WADDR_WIDTH-1:0] a);
        logic [WADDR_WIDTH-1:0] m;
        logic                   run;
        m   = '0;
        run = 1'b1;
        for (int i = 0; i < WADDR_WIDTH; i++) begin
            if (run) m[i] = 1'b1;
            run = run & a[i];
        end
        return m;
    endfunction

    pmp_tor_compare #(
        .WIDTH(WADDR_WIDTH),
        .DEPTH(PMP_ENTRIES)
    ) u_pmp_tor (
        .waddr(waddr),
        .bound(cfg.pmpaddr),
        .tor  (pmp_tor)
    );

    pmp_tor_compare #(
        .WIDTH(WADDR_WIDTH),
        .DEPTH(PMA_ENTRIES)
    ) u_pma_tor (
        .waddr(waddr),
        .bound(cfg.pmaaddr),
        .tor  (pma_tor)
    );

    for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_pmp
        logic [WADDR_WIDTH-1:0] ignore;
        logic                   na4;
        logic                   napot;

        assign ignore = napot_mask(cfg.pmpaddr[i]);
        assign na4    = waddr == cfg.pmpaddr[i];
        assign napot  = (waddr & ~ignore) == (cfg.pmpaddr[i] & ~ignore);

        assign pmp_match[i] = ((cfg.pmpcfg[i].a == PMP_TOR) & pmp_tor[i]) |
                              ((cfg.pmpcfg[i].a == PMP_NA4) & na4) |
                              ((cfg.pmpcfg[i].a == PMP_NAPOT) & napot);
    end

    // walking down from the top lets the lowest matching entry win.
    always_comb begin
        hit   = 1'b0;
        hit_r = 1'b0;
        hit_w = 1'b0;
        hit_x = 1'b0;
        hit_l = 1'b0;
        for (int i = PMP_ENTRIES - 1; i >= 0; i--) begin
            if (pmp_match[i]) begin
                hit   = 1'b1;
                hit_r = cfg.pmpcfg[i].r;
                hit_w = cfg.pmpcfg[i].w;
                hit_x = cfg.pmpcfg[i].x;
                hit_l = cfg.pmpcfg[i].l;
            end
        end
    end

    for (genvar i = 0; i < PMA_ENTRIES; i++) begin : g_pma
        assign pma_uc[i] = (cfg.pmacfg[i].a == PMP_TOR) & pma_tor[i] & cfg.pmacfg[i].uc;
    end

    assign uc = |pma_uc;

endmodule

//--- pmp_csr_bank.sv
module pmp_csr_bank import pmp_pkg::*; #(
    parameter int PMP_ENTRIES = pmp_pkg::PMP_ENTRIES,
    parameter int PMA_ENTRIES = pmp_pkg::PMA_ENTRIES
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            csr_we,
    input  csr_sel_e        csr_sel,
    input  logic [2:0]      csr_idx,
    input  logic [XLEN-1:0] csr_wdata,
    output logic [XLEN-1:0] csr_rdata,
    pmp_cfg_if.bank         cfg
);

    pmp_cfg_t [PMP_ENTRIES-1:0]                  pmpcfg_q;
    logic     [PMP_ENTRIES-1:0][WADDR_WIDTH-1:0] pmpaddr_q;
    pma_cfg_t [PMA_ENTRIES-1:0]                  pmacfg_q;
    logic     [PMA_ENTRIES-1:0][WADDR_WIDTH-1:0] pmaaddr_q;
    logic     [PMP_ENTRIES-1:0]                  addr_locked;

    // a locked TOR entry also protects the address below it, which is its base.
    for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_lock
        if (i == PMP_ENTRIES - 1) begin : g_last
            assign addr_locked[i] = pmpcfg_q[i].l;
        end else begin : g_inner
            assign addr_locked[i] = pmpcfg_q[i].l |
                                    (pmpcfg_q[i+1].l & (pmpcfg_q[i+1].a == PMP_TOR));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pmpcfg_q  <= '0;
            pmpaddr_q <= '0;
            pmacfg_q  <= '0;
            pmaaddr_q <= '0;
        end else if (csr_we) begin
            case (csr_sel)
                SEL_PMPCFG: begin
                    for (int i = 0; i < PMP_ENTRIES; i++) begin
                        if (i / 4 == int'(csr_idx) && !pmpcfg_q[i].l) begin
                            pmpcfg_q[i] <= pmp_cfg_t'(csr_wdata[(i % 4) * 8 +: 8] & 8'h9f);
                        end
                    end
                end
                SEL_PMPADDR: begin
                    for (int i = 0; i < PMP_ENTRIES; i++) begin
                        if (i == int'(csr_idx) && !addr_locked[i]) begin
                            pmpaddr_q[i] <= csr_wdata[WADDR_WIDTH-1:0];
                        end
                    end
                end
                SEL_PMACFG: begin
                    for (int i = 0; i < PMA_ENTRIES; i++) begin
                        if (i / 4 == int'(csr_idx)) begin
                            pmacfg_q[i] <= pma_cfg_t'(csr_wdata[(i % 4) * 8 +: 8] & 8'h83);
                        end
                    end
                end
                default: begin
                    for (int i = 0; i < PMA_ENTRIES; i++) begin
                        if (i == int'(csr_idx)) begin
                            pmaaddr_q[i] <= csr_wdata[WADDR_WIDTH-1:0];
                        end
                    end
                end
            endcase
        end
    end

    // reserved bits are never stored, so the read-back packs the registers as they are.
    always_comb begin
        csr_rdata = '0;
        case (csr_sel)
            SEL_PMPCFG: begin
                for (int i = 0; i < PMP_ENTRIES; i++) begin
                    if (i / 4 == int'(csr_idx)) csr_rdata[(i % 4) * 8 +: 8] = pmpcfg_q[i];
                end
            end
            SEL_PMPADDR: begin
                for (int i = 0; i < PMP_ENTRIES; i++) begin
                    if (i == int'(csr_idx)) csr_rdata = XLEN'(pmpaddr_q[i]);
                end
            end
            SEL_PMACFG: begin
                for (int i = 0; i < PMA_ENTRIES; i++) begin
                    if (i / 4 == int'(csr_idx)) csr_rdata[(i % 4) * 8 +: 8] = pmacfg_q[i];
                end
            end
            default: begin
                for (int i = 0; i < PMA_ENTRIES; i++) begin
                    if (i == int'(csr_idx)) csr_rdata = XLEN'(pmaaddr_q[i]);
                end
            end
        endcase
    end

    assign cfg.pmpcfg  = pmpcfg_q;
    assign cfg.pmpaddr = pmpaddr_q;
    assign cfg.pmacfg  = pmacfg_q;
    assign cfg.pmaaddr = pmaaddr_q;

endmodule

//--- pmp_pkg.sv
package pmp_pkg;

    localparam int PADDR_WIDTH = 34;
    // pmpaddr and pmaaddr hold bits [33:2] of the byte address.
    localparam int WADDR_WIDTH = PADDR_WIDTH - 2;
    localparam int XLEN = 32;

    localparam int PMP_ENTRIES = 8;
    localparam int PMA_ENTRIES = 4;

    typedef enum logic [1:0] {
        PMP_OFF   = 2'b00,
        PMP_TOR   = 2'b01,
        PMP_NA4   = 2'b10,
        PMP_NAPOT = 2'b11
    } pmp_mode_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_EXEC  = 2'd2
    } access_e;

    typedef enum logic [1:0] {
        SEL_PMPCFG  = 2'd0,
        SEL_PMPADDR = 2'd1,
        SEL_PMACFG  = 2'd2,
        SEL_PMAADDR = 2'd3
    } csr_sel_e;

    typedef struct packed {
        logic      l;
        logic [1:0] rsvd;
        pmp_mode_e a;
        logic      x;
        logic      w;
        logic      r;
    } pmp_cfg_t;

    // only the TOR encoding of a is active for PMA entries.
    typedef struct packed {
        logic       uc;
        logic [4:0] rsvd;
        logic [1:0] a;
    } pma_cfg_t;

endpackage

//--- pmp_tor_compare.sv
module pmp_tor_compare #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic [WIDTH-1:0]            waddr,
    input  logic [DEPTH-1:0][WIDTH-1:0] bound,
    output logic [DEPTH-1:0]            tor
);

    logic [DEPTH-1:0] below;

    for (genvar i = 0; i < DEPTH; i++) begin : g_cmp
        assign below[i] = waddr < bound[i];
        // the region of entry i starts at the top of entry i-1.
        if (i == 0) begin : g_first
            assign tor[i] = below[i];
        end else begin : g_rest
            assign tor[i] = below[i] & ~below[i-1];
        end
    end

endmodule

//--- pmp_unit.sv
module pmp_unit import pmp_pkg::*; #(
    parameter int PMP_ENTRIES = pmp_pkg::PMP_ENTRIES,
    parameter int PMA_ENTRIES = pmp_pkg::PMA_ENTRIES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   csr_we,
    input  csr_sel_e               csr_sel,
    input  logic [2:0]             csr_idx,
    input  logic [XLEN-1:0]        csr_wdata,
    output logic [XLEN-1:0]        csr_rdata,
    input  logic                   req_valid,
    input  logic [PADDR_WIDTH-1:0] paddr,
    input  access_e                acc,
    input  priv_e                  priv,
    output logic                   resp_valid,
    output logic                   resp_fault,
    output logic                   resp_uc
);

    logic [WADDR_WIDTH-1:0] waddr;
    logic                   hit;
    logic                   hit_r;
    logic                   hit_w;
    logic                   hit_x;
    logic                   hit_l;
    logic                   uc;

    pmp_cfg_if #(
        .PMP_ENTRIES(PMP_ENTRIES),
        .PMA_ENTRIES(PMA_ENTRIES)
    ) cfg_if ();

    pmp_csr_bank #(
        .PMP_ENTRIES(PMP_ENTRIES),
        .PMA_ENTRIES(PMA_ENTRIES)
    ) u_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_we   (csr_we),
        .csr_sel  (csr_sel),
        .csr_idx  (csr_idx),
        .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata),
        .cfg      (cfg_if.bank)
    );

    pmp_check #(
        .PMP_ENTRIES(PMP_ENTRIES),
        .PMA_ENTRIES(PMA_ENTRIES)
    ) u_check (
        .waddr(waddr),
        .cfg  (cfg_if.check),
        .hit  (hit),
        .hit_r(hit_r),
        .hit_w(hit_w),
        .hit_x(hit_x),
        .hit_l(hit_l),
        .uc   (uc)
    );

    pmp_access_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .paddr     (paddr),
        .acc       (acc),
        .priv      (priv),
        .hit       (hit),
        .hit_r     (hit_r),
        .hit_w     (hit_w),
        .hit_x     (hit_x),
        .hit_l     (hit_l),
        .uc        (uc),
        .waddr     (waddr),
        .resp_valid(resp_valid),
        .resp_fault(resp_fault),
        .resp_uc   (resp_uc)
    );

endmodule

//--- pmp_unit_assertions.sv
module pmp_unit_assertions (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic resp_valid,
    input logic resp_fault,
    input logic resp_uc
);

    // a request sampled at one edge leaves the second stage two edges later.
    resp_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 1) && $past(rst_n, 2)) |-> (resp_valid == $past(req_valid, 2))
    ) else $error("resp_valid does not follow req_valid by two cycles");

    reset_clears: assert property (
        @(posedge clk)
        !rst_n |=> (!resp_valid && !resp_fault && !resp_uc)
    ) else $error("response outputs are not cleared by reset");

endmodule

bind pmp_access_ctrl pmp_unit_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .resp_valid(resp_valid),
    .resp_fault(resp_fault),
    .resp_uc   (resp_uc)
);

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_pmp_unit -f sources.f -o sim_pmp_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_pmp_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

//--- sources.f
pmp_pkg.sv
pmp_cfg_if.sv
pmp_csr_bank.sv
pmp_tor_compare.sv
pmp_check.sv
pmp_access_ctrl.sv
pmp_unit.sv
pmp_unit_assertions.sv
tb_pmp_unit.sv

//--- tb_pmp_unit.sv
module tb_pmp_unit import pmp_pkg::*; ();

    localparam int PMP_N = 8;
    localparam int PMA_N = 4;

    logic                   clk;
    logic                   rst_n;
    logic                   csr_we;
    csr_sel_e               csr_sel;
    logic [2:0]             csr_idx;
    logic [XLEN-1:0]        csr_wdata;
    logic [XLEN-1:0]        csr_rdata;
    logic                   req_valid;
    logic [PADDR_WIDTH-1:0] paddr;
    access_e                acc;
    priv_e                  priv;
    logic                   resp_valid;
    logic                   resp_fault;
    logic                   resp_uc;

    // shadow copy of the entry registers as software should see them.
    logic [7:0]  sh_pmpcfg [PMP_N];
    logic [31:0] sh_pmpaddr [PMP_N];
    logic [7:0]  sh_pmacfg [PMA_N];
    logic [31:0] sh_pmaaddr [PMA_N];

    integer seed;
    int     errors;
    int     timeouts;

    pmp_unit #(
        .PMP_ENTRIES(PMP_N),
        .PMA_ENTRIES(PMA_N)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_we    (csr_we),
        .csr_sel   (csr_sel),
        .csr_idx   (csr_idx),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .req_valid (req_valid),
        .paddr     (paddr),
        .acc       (acc),
        .priv      (priv),
        .resp_valid(resp_valid),
        .resp_fault(resp_fault),
        .resp_uc   (resp_uc)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        req_valid = 1'b0;
        csr_we = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < PMP_N; i++) begin
            sh_pmpcfg[i] = '0;
            sh_pmpaddr[i] = '0;
        end
        for (int i = 0; i < PMA_N; i++) begin
            sh_pmacfg[i] = '0;
            sh_pmaaddr[i] = '0;
        end
    endtask

    task automatic csr_write(input csr_sel_e sel, input logic [2:0] idx, input logic [31:0] data);
        int         e;
        logic [7:0] b;
        e = int'(idx);
        @(negedge clk);
        csr_we = 1'b1;
        csr_sel = sel;
        csr_idx = idx;
        csr_wdata = data;
        case (sel)
            SEL_PMPCFG: begin
                for (int i = 0; i < PMP_N; i++) begin
                    b = data[(i % 4) * 8 +: 8];
                    if (i / 4 == e && !sh_pmpcfg[i][7]) begin
                        sh_pmpcfg[i] = {b[7], 2'b00, b[4:0]};
                    end
                end
            end
            SEL_PMPADDR: begin
                // the base of a locked TOR entry is frozen along with it.
                if (e < PMP_N && !sh_pmpcfg[e][7] && !(e < PMP_N - 1 && sh_pmpcfg[e+1][7] &&
                        sh_pmpcfg[e+1][4:3] == 2'b01)) begin
                    sh_pmpaddr[e] = data;
                end
            end
            SEL_PMACFG: begin
                for (int i = 0; i < PMA_N; i++) begin
                    b = data[(i % 4) * 8 +: 8];
                    if (i / 4 == e) begin
                        sh_pmacfg[i] = {b[7], 5'b00000, b[1:0]};
                    end
                end
            end
            default: begin
                if (e < PMA_N) begin
                    sh_pmaaddr[e] = data;
                end
            end
        endcase
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    function automatic logic [31:0] expected_rdata(input csr_sel_e sel, input int idx);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < 4; b++) begin
            if (sel == SEL_PMPCFG && idx * 4 + b < PMP_N) begin
                v[b * 8 +: 8] = sh_pmpcfg[idx * 4 + b];
            end
            if (sel == SEL_PMACFG && idx * 4 + b < PMA_N) begin
                v[b * 8 +: 8] = sh_pmacfg[idx * 4 + b];
            end
        end
        if (sel == SEL_PMPADDR && idx < PMP_N) begin
            v = sh_pmpaddr[idx];
        end
        if (sel == SEL_PMAADDR && idx < PMA_N) begin
            v = sh_pmaaddr[idx];
        end
        return v;
    endfunction

    task automatic check_all(input string name);
        logic [31:0] exp;
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 8; i++) begin
                @(negedge clk);
                csr_sel = csr_sel_e'(2'(s));
                csr_idx = 3'(i);
                exp = expected_rdata(csr_sel_e'(2'(s)), i);
                @(posedge clk);
                assert (csr_rdata === exp) else begin
                    errors++;
                    $display("FAILED %s sel %0d idx %0d: expected %h, actual %h",
                             name, s, i, exp, csr_rdata);
                end
            end
        end
    endtask

    task automatic random_writes(input int count, input bit with_locks);
        logic [31:0] r;
        logic [31:0] data;
        repeat (count) begin
            r = next_rand();
            data = next_rand();
            if (!with_locks && r[1:0] == 2'd0) begin
                data = data & 32'h7f7f7f7f;
            end
            csr_write(csr_sel_e'(r[1:0]), r[4:2], data);
        end
    endtask

    // small address values keep the random regions dense around the test addresses.
    task automatic randomize_entries(input bit with_locks);
        logic [31:0] cfg_word;
        for (int i = 0; i < PMP_N; i++) begin
            csr_write(SEL_PMPADDR, 3'(i), next_rand() & 32'h3ff);
        end
        for (int i = 0; i < PMA_N; i++) begin
            csr_write(SEL_PMAADDR, 3'(i), next_rand() & 32'h3ff);
        end
        csr_write(SEL_PMACFG, 3'd0, next_rand() | 32'h01010101);
        for (int i = 0; i < 2; i++) begin
            cfg_word = next_rand();
            if (!with_locks) begin
                cfg_word = cfg_word & 32'h7f7f7f7f;
            end
            csr_write(SEL_PMPCFG, 3'(i), cfg_word);
        end
    endtask

    function automatic logic entry_matches(input int i, input logic [31:0] wa);
        logic [31:0] lo;
        logic [31:0] care;
        int          t;
        lo = (i == 0) ? 32'd0 : sh_pmpaddr[(i == 0) ? 0 : i - 1];
        case (sh_pmpcfg[i][4:3])
            2'b01: return wa >= lo && wa < sh_pmpaddr[i];
            2'b10: return wa == sh_pmpaddr[i];
            2'b11: begin
                t = 0;
                while (t < 32 && sh_pmpaddr[i][t]) begin
                    t++;
                end
                // t trailing ones free the word address bits t down to 0.
                care = ~((32'd2 << t) - 32'd1);
                return (wa & care) == (sh_pmpaddr[i] & care);
            end
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic expect_fault(input logic [31:0] wa, input access_e a, input priv_e p);
        logic hit;
        logic perm;
        logic locked;
        hit = 1'b0;
        perm = 1'b0;
        locked = 1'b0;
        for (int i = 0; i < PMP_N; i++) begin
            if (!hit && entry_matches(i, wa)) begin
                hit = 1'b1;
                locked = sh_pmpcfg[i][7];
                case (a)
                    ACC_READ:  perm = sh_pmpcfg[i][0];
                    ACC_WRITE: perm = sh_pmpcfg[i][1];
                    default:   perm = sh_pmpcfg[i][2];
                endcase
            end
        end
        if (p == PRIV_M) begin
            return hit && locked && !perm;
        end
        return !(hit && perm);
    endfunction

    function automatic logic expect_uc(input logic [31:0] wa);
        logic [31:0] lo;
        logic        any_uc;
        any_uc = 1'b0;
        for (int i = 0; i < PMA_N; i++) begin
            lo = (i == 0) ? 32'd0 : sh_pmaaddr[(i == 0) ? 0 : i - 1];
            if (sh_pmacfg[i][7] && sh_pmacfg[i][1:0] == 2'b01 &&
                    wa >= lo && wa < sh_pmaaddr[i]) begin
                any_uc = 1'b1;
            end
        end
        return any_uc;
    endfunction

    // priv_sel picks S or U (0), M (1) or any of the three (2).
    task automatic run_requests(input string name, input int count, input int priv_sel,
                                input bit dense);
        int          cyc;
        int          sent;
        int          got;
        int          a_sel;
        logic [31:0] r;
        logic [31:0] wa;
        logic [1:0]  exp;
        int          due_q[$];
        logic [1:0]  exp_q[$];
        cyc = 0;
        sent = 0;
        got = 0;
        while (sent < count || due_q.size() > 0) begin
            @(negedge clk);
            cyc++;
            if (cyc > count * 4 + 20) begin
                $display("timeout: %s is still waiting for %0d responses", name, due_q.size());
                timeouts++;
                break;
            end
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                void'(due_q.pop_front());
                exp = exp_q.pop_front();
                assert (resp_valid === 1'b1) else begin
                    errors++;
                    $display("FAILED %s resp_valid %0d: expected 1, actual %b",
                             name, got, resp_valid);
                end
                assert ({resp_fault, resp_uc} === exp) else begin
                    errors++;
                    $display("FAILED %s fault/uc %0d: expected %b, actual %b",
                             name, got, exp, {resp_fault, resp_uc});
                end
                got++;
            end else begin
                assert (resp_valid === 1'b0) else begin
                    errors++;
                    $display("FAILED %s idle resp_valid: expected 0, actual %b", name, resp_valid);
                end
            end
            req_valid = 1'b0;
            r = next_rand();
            if (sent < count && (dense || r[0])) begin
                wa = (r[4:2] == 3'd0) ? next_rand() : (next_rand() & 32'h3ff);
                a_sel = int'(r[15:8]) % 3;
                req_valid = 1'b1;
                paddr = {wa, r[6:5]};
                acc = access_e'(2'(a_sel));
                if (priv_sel == 1 || (priv_sel == 2 && r[17])) begin
                    priv = PRIV_M;
                end else begin
                    priv = r[16] ? PRIV_S : PRIV_U;
                end
                due_q.push_back(cyc + 2);
                exp_q.push_back({expect_fault(wa, acc, priv), expect_uc(wa)});
                sent++;
            end
        end
        req_valid = 1'b0;
    endtask

    initial begin
        seed = 32'hef9e9b23;
        errors = 0;
        timeouts = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        csr_we = 1'b0;
        csr_sel = SEL_PMPCFG;
        csr_idx = 3'd0;
        csr_wdata = '0;
        req_valid = 1'b0;
        paddr = '0;
        acc = ACC_READ;
        priv = PRIV_M;
        apply_reset();

        random_writes(60, 1'b0);
        check_all("readback");

        // entry 3 becomes a locked TOR region, which also freezes pmpaddr2.
        csr_write(SEL_PMPCFG, 3'd0, 32'h8900_0000);
        random_writes(80, 1'b1);
        csr_write(SEL_PMPADDR, 3'd2, next_rand());
        csr_write(SEL_PMPCFG, 3'd0, 32'h0000_0000);
        check_all("lock");

        for (int round = 0; round < 4; round++) begin
            apply_reset();
            randomize_entries(round[0]);
            run_requests("match_su", 200, 0, 1'b0);
        end
        for (int round = 0; round < 3; round++) begin
            apply_reset();
            randomize_entries(1'b1);
            run_requests("m_mode", 200, 1, 1'b0);
        end
        apply_reset();
        randomize_entries(1'b0);
        run_requests("pipeline", 300, 2, 1'b1);

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
